/* ddr3_ddl.f */
verilog/ddr3_timing_pkg.sv
verilog/ddl_types_pkg.sv
verilog/ddl_cmd_sequencer.sv
verilog/ddl_wr_scheduler.sv
verilog/ddl_phy_port.sv
verilog/ddr3_ddl.sv
dv/ddr3_ddl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ddr3_ddl_tb
FILELIST  ?= ddr3_ddl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/ddr3_ddl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr3_ddl_tb;
  import ddl_types_pkg::*;
  import ddr3_timing_pkg::*;

  logic      clock;
  logic      reset;
  logic      ddr_cke_i;
  logic      ctl_req_i;
  ddl_cmd_t  ctl_cmd_i;
  logic      ctl_rdy_o;
  logic      ctl_err_o;
  logic      mem_wvalid_i;
  logic      mem_wready_o;
  wr_beat_t  mem_wr_i;
  logic      mem_rvalid_o;
  dfi_data_t mem_rdata_o;
  logic      mem_rlast_o;
  ddl_cmd_t  dfi_cmd_o;
  logic      dfi_wren_o;
  logic      dfi_odt_o;
  wr_beat_t  dfi_wr_o;
  logic      dfi_rvld_i;
  dfi_data_t dfi_rdata_i;

  // Reference model state, all in clock edges
  int          cyc = 0;
  int          rdy_at = 0;
  int          win_old = -100;
  int          win_new = -100;
  int          rd_beats = 0;
  logic        row_open = 1'b0;
  logic        exp_err = 1'b0;
  ddl_cmd_t    exp_cmd = '{cmd: NOOP, bank: '0, addr: '0};
  logic        exp_rdy;
  logic        exp_wren;
  logic [31:0] seed = 32'h938a_4f87;
  int          mismatch_count = 0;
  int          timeout_count = 0;

  ddr3_ddl dut (.*);

  initial begin
    clock = 1'b0;
    forever begin
      #20 clock = ~clock;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Minimum distance after each command class
  function automatic int spacing_of(ddl_cmd_t c);
    case (c.cmd)
      ACTV:    return T_RCD;
      READ:    return c.addr[10] ? T_RDA : T_RD_RD;
      WRIT:    return c.addr[10] ? T_WRA : T_WR_WR;
      PREC:    return T_RP;
      REFR:    return T_RFC;
      MODE:    return T_MRD;
      ZQCL:    return T_ZQINIT;
      default: return 0;
    endcase
  endfunction

  function automatic logic cmd_legal(ddr_cmd_e cmd, logic open);
    case (cmd)
      READ, WRIT:       return open;
      MODE, REFR, ZQCL: return !open;
      default:          return 1'b1;
    endcase
  endfunction

  assign exp_rdy  = (cyc >= rdy_at);
  assign exp_wren = (cyc >= win_old && cyc < win_old + BURST_CYCLES) ||
                    (cyc >= win_new && cyc < win_new + BURST_CYCLES);

  always @(posedge clock) begin
    cyc     <= cyc + 1;
    exp_err <= 1'b0;
    exp_cmd <= '{cmd: NOOP, bank: '0, addr: '0};
    if (reset || !ddr_cke_i) begin
      rdy_at   <= cyc + 1 + T_INIT;
      row_open <= 1'b0;
    end else if (ctl_req_i && exp_rdy && !cmd_legal(ctl_cmd_i.cmd, row_open)) begin
      exp_err <= 1'b1;
    end else if (ctl_req_i && exp_rdy) begin
      if (spacing_of(ctl_cmd_i) != 0) begin
        rdy_at <= cyc + 1 + spacing_of(ctl_cmd_i);
      end
      if (ctl_cmd_i.cmd != NOOP) begin
        exp_cmd <= ctl_cmd_i;
      end
      // Window opens WR_DELAY edges after the accepting edge
      if (ctl_cmd_i.cmd == WRIT) begin
        win_old <= win_new;
        win_new <= cyc + 1 + WR_DELAY;
      end
      if (ctl_cmd_i.cmd == ACTV) begin
        row_open <= 1'b1;
      end else if (ctl_cmd_i.addr[10] && ctl_cmd_i.cmd inside {PREC, READ, WRIT}) begin
        row_open <= 1'b0;
      end
    end
    if (reset) begin
      rd_beats <= 0;
      win_old  <= -100;
      win_new  <= -100;
    end else if (dfi_rvld_i) begin
      rd_beats <= rd_beats + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] expd,
                                 input logic [63:0] act);
    mismatch_count++;
    $display("mismatch %s: expected %h, actual %h", name, expd, act);
  endtask

  assert property (@(posedge clock) disable iff (reset)
    {ctl_rdy_o, ctl_err_o} == {exp_rdy, exp_err})
    else report_mismatch("ready/error", 64'($sampled({exp_rdy, exp_err})),
                         64'($sampled({ctl_rdy_o, ctl_err_o})));
  assert property (@(posedge clock) disable iff (reset) dfi_cmd_o == exp_cmd)
    else report_mismatch("dfi command", 64'($sampled(exp_cmd)), 64'($sampled(dfi_cmd_o)));
  assert property (@(posedge clock) disable iff (reset)
    {dfi_wren_o, dfi_odt_o, mem_wready_o} == {3{exp_wren}})
    else report_mismatch("write window", 64'($sampled({3{exp_wren}})),
                         64'($sampled({dfi_wren_o, dfi_odt_o, mem_wready_o})));
  assert property (@(posedge clock) disable iff (reset) dfi_wr_o == mem_wr_i)
    else report_mismatch("write data", 64'($sampled(mem_wr_i)), 64'($sampled(dfi_wr_o)));
  // Every fourth valid beat closes a burst
  assert property (@(posedge clock) disable iff (reset)
    {mem_rvalid_o, mem_rdata_o, mem_rlast_o} == {dfi_rvld_i, dfi_rdata_i,
      dfi_rvld_i && (rd_beats % BURST_CYCLES == BURST_CYCLES - 1)})
    else report_mismatch("read path", 64'($sampled({dfi_rvld_i, dfi_rdata_i,
                         dfi_rvld_i && (rd_beats % BURST_CYCLES == BURST_CYCLES - 1)})),
                         64'($sampled({mem_rvalid_o, mem_rdata_o, mem_rlast_o})));

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // One clock, then fresh random write and read data
  task automatic step();
    @(posedge clock);
    #2;
    mem_wr_i.data = next_random();
    mem_wr_i.mask = dfi_mask_t'(next_random() >> 28);
    dfi_rdata_i   = next_random();
    dfi_rvld_i    = (next_random() >= 32'h8000_0000);
  endtask

  task automatic issue_cmd(input ddr_cmd_e cmd, input logic ap);
    int tries = 0;
    while (!ctl_rdy_o && timeout_count == 0) begin
      if (tries == T_ZQINIT * 2) begin
        $display("timeout: ctl_rdy_o stayed low for %0d cycles", tries);
        timeout_count++;
      end else begin
        tries++;
        step();
      end
    end
    if (timeout_count == 0) begin
      ctl_req_i          = 1'b1;
      ctl_cmd_i.cmd      = cmd;
      ctl_cmd_i.bank     = bank_t'(next_random() >> 29);
      ctl_cmd_i.addr     = row_addr_t'(next_random() >> 19);
      ctl_cmd_i.addr[10] = ap;
      step();
      ctl_req_i = 1'b0;
    end
  endtask

  initial begin
    reset        = 1'b1;
    ddr_cke_i    = 1'b1;
    ctl_req_i    = 1'b0;
    ctl_cmd_i    = '{cmd: NOOP, bank: '0, addr: '0};
    mem_wvalid_i = 1'b1;
    mem_wr_i     = '0;
    dfi_rvld_i   = 1'b0;
    dfi_rdata_i  = '0;
    repeat (16) step();
    reset = 1'b0;

    // Every command class in a legal order
    issue_cmd(MODE, 1'b0);
    issue_cmd(REFR, 1'b0);
    issue_cmd(ZQCL, 1'b0);
    issue_cmd(ACTV, 1'b0);
    issue_cmd(READ, 1'b0);
    issue_cmd(READ, 1'b1);
    issue_cmd(ACTV, 1'b0);
    issue_cmd(WRIT, 1'b0);
    issue_cmd(WRIT, 1'b1);
    issue_cmd(PREC, 1'b1);

    // READ with rows closed, REFRESH with a row open
    issue_cmd(READ, 1'b0);
    issue_cmd(ACTV, 1'b0);
    issue_cmd(REFR, 1'b0);

    // Back-to-back write bursts
    issue_cmd(WRIT, 1'b0);
    issue_cmd(WRIT, 1'b0);
    issue_cmd(WRIT, 1'b0);
    issue_cmd(PREC, 1'b1);
    issue_cmd(NOOP, 1'b0);
    repeat (WR_DELAY + BURST_CYCLES) step();

    // CKE low restarts the init hold-off
    ddr_cke_i = 1'b0;
    repeat (3) step();
    ddr_cke_i = 1'b1;
    issue_cmd(MODE, 1'b0);
    repeat (T_MRD + 2) step();
    finish_run();
  end

endmodule

`default_nettype wire

/* verilog/ddr3_ddl.sv */
`timescale 1ns/10ps
`default_nettype none

module ddr3_ddl (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     ddr_cke_i,

  // Memory controller commands
  input  logic                     ctl_req_i,
  input  ddl_types_pkg::ddl_cmd_t  ctl_cmd_i,
  output logic                     ctl_rdy_o,
  output logic                     ctl_err_o,

  // Write data from the controller
  input  logic                     mem_wvalid_i,
  output logic                     mem_wready_o,
  input  ddl_types_pkg::wr_beat_t  mem_wr_i,

  // Read data to the controller
  output logic                     mem_rvalid_o,
  output ddl_types_pkg::dfi_data_t mem_rdata_o,
  output logic                     mem_rlast_o,

  // DFI side
  output ddl_types_pkg::ddl_cmd_t  dfi_cmd_o,
  output logic                     dfi_wren_o,
  output logic                     dfi_odt_o,
  output ddl_types_pkg::wr_beat_t  dfi_wr_o,
  input  logic                     dfi_rvld_i,
  input  ddl_types_pkg::dfi_data_t dfi_rdata_i
);
  import ddl_types_pkg::*;

  logic     issue;
  ddl_cmd_t issued_cmd;
  logic     wr_accept;
  logic     wr_window;

  ddl_cmd_sequencer u_sequencer (
    .clock       (clock),
    .reset       (reset),
    .ddr_cke_i   (ddr_cke_i),
    .ctl_req_i   (ctl_req_i),
    .ctl_cmd_i   (ctl_cmd_i),
    .ctl_rdy_o   (ctl_rdy_o),
    .ctl_err_o   (ctl_err_o),
    .issue_o     (issue),
    .dfi_cmd_o   (issued_cmd),
    .wr_accept_o (wr_accept)
  );

  ddl_wr_scheduler u_wr_scheduler (
    .clock       (clock),
    .reset       (reset),
    .wr_accept_i (wr_accept),
    .wr_window_o (wr_window)
  );

  ddl_phy_port u_phy_port (
    .clock        (clock),
    .reset        (reset),
    .issue_i      (issue),
    .cmd_i        (issued_cmd),
    .wr_window_i  (wr_window),
    .mem_wvalid_i (mem_wvalid_i),
    .mem_wready_o (mem_wready_o),
    .mem_wr_i     (mem_wr_i),
    .dfi_cmd_o    (dfi_cmd_o),
    .dfi_wren_o   (dfi_wren_o),
    .dfi_odt_o    (dfi_odt_o),
    .dfi_wr_o     (dfi_wr_o),
    .dfi_rvld_i   (dfi_rvld_i),
    .dfi_rdata_i  (dfi_rdata_i),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rdata_o  (mem_rdata_o),
    .mem_rlast_o  (mem_rlast_o)
  );

endmodule

`default_nettype wire

/* verilog/ddl_phy_port.sv */
`timescale 1ns/10ps
`default_nettype none

module ddl_phy_port (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     issue_i,
  input  ddl_types_pkg::ddl_cmd_t  cmd_i,
  input  logic                     wr_window_i,
  input  logic                     mem_wvalid_i,
  output logic                     mem_wready_o,
  input  ddl_types_pkg::wr_beat_t  mem_wr_i,
  output ddl_types_pkg::ddl_cmd_t  dfi_cmd_o,
  output logic                     dfi_wren_o,
  output logic                     dfi_odt_o,
  output ddl_types_pkg::wr_beat_t  dfi_wr_o,
  input  logic                     dfi_rvld_i,
  input  ddl_types_pkg::dfi_data_t dfi_rdata_i,
  output logic                     mem_rvalid_o,
  output ddl_types_pkg::dfi_data_t mem_rdata_o,
  output logic                     mem_rlast_o
);
  import ddl_types_pkg::*;

  beat_cnt_t rd_beat;

  // Command bus idles at NOOP between issued commands
  assign dfi_cmd_o = issue_i ? cmd_i : CMD_IDLE;

  // Write window drives the strobe, the upstream pop and termination alike
  assign dfi_wren_o   = wr_window_i;
  assign mem_wready_o = wr_window_i;
  assign dfi_odt_o    = wr_window_i;
  assign dfi_wr_o     = mem_wr_i;

  // Read data straight through
  assign mem_rvalid_o = dfi_rvld_i;
  assign mem_rdata_o  = dfi_rdata_i;
  assign mem_rlast_o  = dfi_rvld_i && (rd_beat == '1);

  // Counts valid read beats modulo one burst
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_beat <= '0;
    end else if (dfi_rvld_i) begin
      rd_beat <= rd_beat + 1'b1;
    end
  end

  // No back-pressure, the controller has to supply data for every write beat
  assert property (@(posedge clock) disable iff (reset)
    wr_window_i |-> mem_wvalid_i)
    else $error("DDL: write data missing during write window");

endmodule

`default_nettype wire

/* verilog/ddl_wr_scheduler.sv */
`timescale 1ns/10ps
`default_nettype none

module ddl_wr_scheduler (
  input  logic clock,
  input  logic reset,
  input  logic wr_accept_i,
  output logic wr_window_o
);
  import ddl_types_pkg::*;
  import ddr3_timing_pkg::*;

  logic [WR_DELAY-1:0] wr_line;
  beat_cnt_t           burst_cnt;
  logic                win_start;

  // The accept pulse is one cycle late already, so the tail lands on t+WR_DELAY
  assign win_start   = wr_line[WR_DELAY-1];
  assign wr_window_o = win_start || (burst_cnt != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_line   <= '0;
      burst_cnt <= '0;
    end else begin
      wr_line <= {wr_line[WR_DELAY-2:0], wr_accept_i};
      // First beat comes from the tail, the counter covers the rest
      if (win_start) begin
        burst_cnt <= beat_cnt_t'(BURST_CYCLES - 1);
      end else if (burst_cnt != '0) begin
        burst_cnt <= burst_cnt - 1'b1;
      end
    end
  end

  // WRITE spacing keeps consecutive windows from overlapping
  assert property (@(posedge clock) disable iff (reset)
    win_start |=> !win_start [*BURST_CYCLES-1])
    else $error("DDL: write window started while the previous one was open");

endmodule

`default_nettype wire

/* verilog/ddl_cmd_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module ddl_cmd_sequencer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ddr_cke_i,
  input  logic                    ctl_req_i,
  input  ddl_types_pkg::ddl_cmd_t ctl_cmd_i,
  output logic                    ctl_rdy_o,
  output logic                    ctl_err_o,
  output logic                    issue_o,
  output ddl_types_pkg::ddl_cmd_t dfi_cmd_o,
  output logic                    wr_accept_o
);
  import ddl_types_pkg::*;
  import ddr3_timing_pkg::*;

  ddl_state_e            state;
  logic [DELAY_BITS-1:0] count;
  logic [DELAY_BITS-1:0] spacing;
  logic                  auto_pre;
  logic                  legal;
  logic                  req_ok;
  logic                  accept;

  // A10 selects auto-precharge on READ/WRITE, and all banks on PRECHARGE
  assign auto_pre = ctl_cmd_i.addr[10];
  assign req_ok   = ctl_req_i && ctl_rdy_o;
  assign accept   = req_ok && legal;

  // Column commands need an open row, housekeeping needs all rows closed
  always_comb begin
    case (ctl_cmd_i.cmd)
      READ, WRIT:       legal = (state == ACTIVE);
      MODE, REFR, ZQCL: legal = (state == IDLE);
      default:          legal = 1'b1;
    endcase
  end

  // Minimum distance to the next command, per class
  always_comb begin
    case (ctl_cmd_i.cmd)
      ACTV:    spacing = DELAY_BITS'(T_RCD);
      READ:    spacing = auto_pre ? DELAY_BITS'(T_RDA) : DELAY_BITS'(T_RD_RD);
      WRIT:    spacing = auto_pre ? DELAY_BITS'(T_WRA) : DELAY_BITS'(T_WR_WR);
      PREC:    spacing = DELAY_BITS'(T_RP);
      REFR:    spacing = DELAY_BITS'(T_RFC);
      MODE:    spacing = DELAY_BITS'(T_MRD);
      ZQCL:    spacing = DELAY_BITS'(T_ZQINIT);
      default: spacing = '0;
    endcase
  end

  // Spacing counter, ready comes back on the edge the count hits zero
  always_ff @(posedge clock) begin
    if (reset || !ddr_cke_i) begin
      count     <= DELAY_BITS'(T_INIT);
      ctl_rdy_o <= 1'b0;
    end else if (accept && spacing != '0) begin
      count     <= spacing;
      ctl_rdy_o <= 1'b0;
    end else if (count != '0) begin
      count     <= count - 1'b1;
      ctl_rdy_o <= (count == DELAY_BITS'(1));
    end
  end

  always_ff @(posedge clock) begin
    if (reset || !ddr_cke_i) begin
      state <= INIT;
    end else begin
      case (state)
        INIT: begin
          // Leave together with ready rising
          if (count == DELAY_BITS'(1)) begin
            state <= IDLE;
          end
        end
        default: begin
          if (accept) begin
            case (ctl_cmd_i.cmd)
              ACTV: state <= ACTIVE;
              PREC, READ, WRIT: begin
                if (auto_pre) begin
                  state <= IDLE;
                end
              end
              default: state <= state;
            endcase
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset || !ddr_cke_i) begin
      issue_o     <= 1'b0;
      ctl_err_o   <= 1'b0;
      wr_accept_o <= 1'b0;
    end else begin
      issue_o     <= accept && (ctl_cmd_i.cmd != NOOP);
      ctl_err_o   <= req_ok && !legal;
      wr_accept_o <= accept && (ctl_cmd_i.cmd == WRIT);
    end
  end

  // Command payload, only meaningful while issue_o is high
  always_ff @(posedge clock) begin
    if (accept) begin
      dfi_cmd_o <= ctl_cmd_i;
    end
  end

  // The counter must have drained before the cycle a command went out
  assert property (@(posedge clock) disable iff (reset || !ddr_cke_i)
    issue_o |-> $past(count) == '0)
    else $error("DDL: command issued while spacing counter was busy");

endmodule

`default_nettype wire

/* verilog/ddl_types_pkg.sv */
`default_nettype none

package ddl_types_pkg;

  // DDR3 command encoding as {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    MODE = 3'b000,
    REFR = 3'b001,
    PREC = 3'b010,
    ACTV = 3'b011,
    WRIT = 3'b100,
    READ = 3'b101,
    ZQCL = 3'b110,
    NOOP = 3'b111
  } ddr_cmd_e;

  // Row tracker, all banks share one state
  typedef enum logic [1:0] {
    INIT,
    IDLE,
    ACTIVE
  } ddl_state_e;

  typedef logic [2:0] bank_t;
  typedef logic [12:0] row_addr_t;
  typedef logic [31:0] dfi_data_t;
  typedef logic [3:0] dfi_mask_t;

  // Counts clock cycles within one burst
  typedef logic [1:0] beat_cnt_t;

  typedef struct packed {
    ddr_cmd_e  cmd;
    bank_t     bank;
    row_addr_t addr;
  } ddl_cmd_t;

  typedef struct packed {
    dfi_mask_t mask;
    dfi_data_t data;
  } wr_beat_t;

  // What the command bus shows between issued commands
  localparam ddl_cmd_t CMD_IDLE = '{cmd: NOOP, bank: '0, addr: '0};

endpackage

`default_nettype wire

/* verilog/ddr3_timing_pkg.sv */
`default_nettype none

package ddr3_timing_pkg;

  // All values are in controller clock cycles

  // Hold-off after reset, or after CKE is raised again
  localparam int T_INIT = 8;

  // Row activate to READ/WRITE
  localparam int T_RCD = 2;

  // Back-to-back column commands to an open row
  localparam int T_RD_RD = 4;
  localparam int T_WR_WR = 4;

  // Column commands with auto-precharge, until the bank is idle again
  localparam int T_RDA = 6;
  localparam int T_WRA = 12;

  // Precharge to the next row command
  localparam int T_RP = 2;

  // Refresh cycle time
  localparam int T_RFC = 11;

  // Mode-register set to the next command
  localparam int T_MRD = 4;

  // Long ZQ calibration, as used during initialisation
  localparam int T_ZQINIT = 512;

  // CAS write latency and the extra cycle through the PHY write registers
  localparam int DDR_CWL = 5;
  localparam int PHY_WR_LATENCY = 1;
  localparam int WR_DELAY = DDR_CWL - PHY_WR_LATENCY;

  // BL8 is four clock cycles of DDR data
  localparam int BURST_CYCLES = 4;

  // Spacing counter must hold the longest delay
  localparam int DELAY_BITS = $clog2(T_ZQINIT + 1);

endpackage

`default_nettype wire
